//--- common/rom_pkg.sv
/* ROM subsystem shared types */

`default_nettype none

package rom_pkg;

    // SDRAM side, addressed in halfwords
    typedef logic [21:0] sdram_addr_t;
    typedef logic [31:0] sdram_word_t;

    // Client byte address as seen by a game CPU or layer
    typedef logic [15:0] rom_addr_t;

    typedef logic [1:0] client_idx_t;

    // Lower number wins arbitration
    localparam client_idx_t CLIENT_MAIN = 2'd0;
    localparam client_idx_t CLIENT_SND  = 2'd1;
    localparam client_idx_t CLIENT_CHAR = 2'd2;
    localparam int NUM_CLIENTS = 3;

    typedef struct packed {
        sdram_addr_t char_base;
        sdram_addr_t snd_base;
        sdram_addr_t main_base;
    } region_bases_t;

    localparam region_bases_t DEFAULT_BASES = '{
        char_base: 22'h008000,
        snd_base:  22'h006000,
        main_base: 22'h000000
    };

    // Slot to arbiter request, word_addr is even and region relative
    typedef struct packed {
        logic        req;
        sdram_addr_t word_addr;
    } fetch_req_t;

    typedef struct packed {
        logic        req;
        client_idx_t sel;
        sdram_addr_t base;
    } cfg_write_t;

    // PROM map in loader byte addresses, 256 bytes per PROM
    localparam logic [21:0] PROM_START = 22'h030000;
    localparam int NUM_PROMS = 6;
    typedef logic [NUM_PROMS-1:0] prom_we_t;

    // Game reset tail after the download ends
    localparam int RESET_TAIL = 2;
    localparam int TAIL_W = $clog2(RESET_TAIL + 1);
    typedef logic [TAIL_W-1:0] tail_cnt_t;

endpackage

`default_nettype wire

//--- rom_fetch/rom_client_slot.sv
/* One-word ROM cache slot */

`timescale 1ns/10ps
`default_nettype none

module rom_client_slot #(
    parameter type data_t = logic [7:0]
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cs,
    input  rom_pkg::rom_addr_t   addr,
    output data_t                data,
    output logic                 ok,
    output rom_pkg::fetch_req_t  fetch,
    input  logic                 fetch_ack,
    input  rom_pkg::sdram_word_t fetch_data
);

    rom_pkg::sdram_addr_t half_addr;
    rom_pkg::sdram_addr_t word_addr;
    rom_pkg::sdram_addr_t tag;
    rom_pkg::sdram_addr_t req_addr;
    rom_pkg::sdram_word_t cache_word;
    logic [15:0]          half_sel;
    logic                 valid;
    logic                 hit;
    logic                 req_q;
    logic                 load;
    logic                 start;

    // Byte clients address halfword addr/2, halfword clients use addr as is
    generate
        if ($bits(data_t) == 8) begin : g_byte
            assign half_addr = {7'd0, addr[15:1]};
            assign data      = addr[0] ? half_sel[15:8] : half_sel[7:0];
        end else begin : g_half
            assign half_addr = {6'd0, addr};
            assign data      = half_sel;
        end
    endgenerate

    // Tag drops the halfword bit
    assign word_addr = {half_addr[21:1], 1'b0};
    assign half_sel  = half_addr[0] ? cache_word[31:16] : cache_word[15:0];

    // Hit shows in the same cycle as the address
    assign hit = valid && (tag == word_addr);
    assign ok  = cs && hit;

    assign load  = req_q && fetch_ack;
    // New miss only once the previous handshake has fully closed
    assign start = !req_q && !fetch_ack && cs && !hit;

    assign fetch = '{req: req_q, word_addr: req_addr};

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= 1'b0;
            valid <= 1'b0;
        end else if (load) begin
            req_q <= 1'b0;
            valid <= 1'b1;
        end else if (start) begin
            req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= word_addr;
        end
        if (load) begin
            cache_word <= fetch_data;
            tag        <= req_addr;
        end
    end

endmodule

`default_nettype wire

//--- rom_fetch/sdram_arbiter.sv
/* SDRAM read arbiter */

`timescale 1ns/10ps
`default_nettype none

module sdram_arbiter (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          downloading,
    input  rom_pkg::region_bases_t                        bases,
    input  rom_pkg::fetch_req_t [rom_pkg::NUM_CLIENTS-1:0] fetch,
    output logic [rom_pkg::NUM_CLIENTS-1:0]               fetch_ack,
    output rom_pkg::sdram_word_t                          fetch_data,
    output logic                                          sdram_req,
    output rom_pkg::sdram_addr_t                          sdram_addr,
    input  logic                                          sdram_ack,
    input  logic                                          data_rdy,
    input  rom_pkg::sdram_word_t                          data_read,
    output logic                                          refresh_en,
    output logic                                          rom_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_ACK
    } state_t;

    state_t               state;
    rom_pkg::client_idx_t grant;
    rom_pkg::client_idx_t pick;
    rom_pkg::tail_cnt_t   tail_cnt;
    logic                 any_req;
    logic                 start;
    logic                 done;

    function automatic rom_pkg::sdram_addr_t base_of(
        input rom_pkg::region_bases_t b,
        input rom_pkg::client_idx_t   idx
    );
        case (idx)
            rom_pkg::CLIENT_MAIN: return b.main_base;
            rom_pkg::CLIENT_SND:  return b.snd_base;
            rom_pkg::CLIENT_CHAR: return b.char_base;
            default:              return '0;
        endcase
    endfunction

    // Fixed priority, lowest index wins
    always_comb begin
        pick    = rom_pkg::CLIENT_MAIN;
        any_req = 1'b0;
        for (int i = rom_pkg::NUM_CLIENTS - 1; i >= 0; i--) begin
            if (fetch[i].req) begin
                pick    = rom_pkg::client_idx_t'(i);
                any_req = 1'b1;
            end
        end
    end

    // rom_ready falls one cycle late, so downloading itself also blocks
    assign start = (state == ST_IDLE) && any_req && rom_ready && !downloading;
    assign done  = (state == ST_WAIT) && data_rdy;

    assign refresh_en = (state != ST_REQ) && (state != ST_WAIT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            grant     <= rom_pkg::CLIENT_MAIN;
            sdram_req <= 1'b0;
            fetch_ack <= '0;
        end else begin
            case (state)
                ST_IDLE: if (start) begin
                    grant     <= pick;
                    sdram_req <= 1'b1;
                    state     <= ST_REQ;
                end
                ST_REQ: if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= ST_WAIT;
                end
                ST_WAIT: if (data_rdy) begin
                    fetch_ack[grant] <= 1'b1;
                    state            <= ST_ACK;
                end
                // Hold ack until the slot drops its request
                ST_ACK: if (!fetch[grant].req) begin
                    fetch_ack <= '0;
                    state     <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= base_of(bases, pick) + fetch[pick].word_addr;
        end
        if (done) begin
            fetch_data <= data_read;
        end
    end

    // Same tail rule as the game reset
    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            tail_cnt  <= rom_pkg::tail_cnt_t'(rom_pkg::RESET_TAIL);
            rom_ready <= 1'b0;
        end else begin
            if (tail_cnt != 0) begin
                tail_cnt <= tail_cnt - 1'b1;
            end
            rom_ready <= (tail_cnt <= 1);
        end
    end

endmodule

`default_nettype wire

//--- logic/rom_download.sv
/* Loader write decoder and game reset */

`timescale 1ns/10ps
`default_nettype none

module rom_download (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 downloading,
    input  logic [21:0]          ioctl_addr,
    input  logic [7:0]           ioctl_data,
    input  logic                 ioctl_wr,
    output rom_pkg::sdram_addr_t prog_addr,
    output logic [7:0]           prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    output rom_pkg::prom_we_t    prom_we,
    output logic                 game_rst
);

    logic [21:0]        prom_off;
    logic               is_prom;
    rom_pkg::prom_we_t  prom_dec;
    rom_pkg::tail_cnt_t tail_cnt;

    assign is_prom  = ioctl_addr >= rom_pkg::PROM_START;
    assign prom_off = ioctl_addr - rom_pkg::PROM_START;

    // 256-byte blocks from PROM_START, anything past the last PROM is dropped
    always_comb begin
        prom_dec = '0;
        if (is_prom && (prom_off[21:8] < 14'(rom_pkg::NUM_PROMS))) begin
            prom_dec[prom_off[10:8]] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= '0;
        end else begin
            prog_we <= ioctl_wr && !is_prom;
            prom_we <= ioctl_wr ? prom_dec : '0;
        end
    end

    // Set mask bit means the lane is kept, even bytes go to the low lane
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            prog_data <= ioctl_data;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            prog_addr <= is_prom ? {14'd0, ioctl_addr[7:0]} : {1'b0, ioctl_addr[21:1]};
        end
    end

    // Reset tail counted from the end of the download
    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            tail_cnt <= rom_pkg::tail_cnt_t'(rom_pkg::RESET_TAIL);
            game_rst <= 1'b1;
        end else begin
            if (tail_cnt != 0) begin
                tail_cnt <= tail_cnt - 1'b1;
            end
            game_rst <= (tail_cnt > 1);
        end
    end

endmodule

`default_nettype wire

//--- logic/region_cfg.sv
/* Region base registers */

`timescale 1ns/10ps
`default_nettype none

module region_cfg (
    input  logic                   clk,
    input  logic                   reset,
    input  rom_pkg::cfg_write_t    cfg,
    output logic                   cfg_ack,
    output rom_pkg::region_bases_t bases
);

    logic take;

    // One write per handshake, taken on the first cycle of req
    assign take = cfg.req && !cfg_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_ack <= 1'b0;
        end else if (take) begin
            cfg_ack <= 1'b1;
        end else if (!cfg.req) begin
            cfg_ack <= 1'b0;
        end
    end

    // Index 3 is acknowledged but has no register
    always_ff @(posedge clk) begin
        if (reset) begin
            bases <= rom_pkg::DEFAULT_BASES;
        end else if (take) begin
            case (cfg.sel)
                rom_pkg::CLIENT_MAIN: bases.main_base <= cfg.base;
                rom_pkg::CLIENT_SND:  bases.snd_base  <= cfg.base;
                rom_pkg::CLIENT_CHAR: bases.char_base <= cfg.base;
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/rom_subsys_top.sv
/* ROM subsystem top */

`timescale 1ns/10ps
`default_nettype none

module rom_subsys_top (
    input  logic                 clk,
    input  logic                 reset,
    // Loader
    input  logic                 downloading,
    input  logic [21:0]          ioctl_addr,
    input  logic [7:0]           ioctl_data,
    input  logic                 ioctl_wr,
    output rom_pkg::sdram_addr_t prog_addr,
    output logic [7:0]           prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    output rom_pkg::prom_we_t    prom_we,
    // Region configuration
    input  rom_pkg::cfg_write_t  cfg,
    output logic                 cfg_ack,
    // Game clients
    input  logic                 main_cs,
    input  rom_pkg::rom_addr_t   main_addr,
    output logic [7:0]           main_data,
    output logic                 main_ok,
    input  logic                 snd_cs,
    input  rom_pkg::rom_addr_t   snd_addr,
    output logic [7:0]           snd_data,
    output logic                 snd_ok,
    input  logic                 char_cs,
    input  rom_pkg::rom_addr_t   char_addr,
    output logic [15:0]          char_data,
    output logic                 char_ok,
    // SDRAM
    output logic                 sdram_req,
    output rom_pkg::sdram_addr_t sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  rom_pkg::sdram_word_t data_read,
    output logic                 refresh_en,
    output logic                 rom_ready,
    output logic                 game_rst
);

    rom_pkg::region_bases_t                         bases;
    rom_pkg::fetch_req_t [rom_pkg::NUM_CLIENTS-1:0] fetch_bus;
    logic [rom_pkg::NUM_CLIENTS-1:0]                fetch_ack;
    rom_pkg::sdram_word_t                           fetch_data;

    rom_download download_i (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .game_rst    (game_rst)
    );

    region_cfg cfg_i (
        .clk     (clk),
        .reset   (reset),
        .cfg     (cfg),
        .cfg_ack (cfg_ack),
        .bases   (bases)
    );

    sdram_arbiter arbiter_i (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .bases       (bases),
        .fetch       (fetch_bus),
        .fetch_ack   (fetch_ack),
        .fetch_data  (fetch_data),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .refresh_en  (refresh_en),
        .rom_ready   (rom_ready)
    );

    rom_client_slot #(.data_t(logic [7:0])) main_slot_i (
        .clk        (clk),
        .reset      (reset),
        .cs         (main_cs),
        .addr       (main_addr),
        .data       (main_data),
        .ok         (main_ok),
        .fetch      (fetch_bus[rom_pkg::CLIENT_MAIN]),
        .fetch_ack  (fetch_ack[rom_pkg::CLIENT_MAIN]),
        .fetch_data (fetch_data)
    );

    rom_client_slot #(.data_t(logic [7:0])) snd_slot_i (
        .clk        (clk),
        .reset      (reset),
        .cs         (snd_cs),
        .addr       (snd_addr),
        .data       (snd_data),
        .ok         (snd_ok),
        .fetch      (fetch_bus[rom_pkg::CLIENT_SND]),
        .fetch_ack  (fetch_ack[rom_pkg::CLIENT_SND]),
        .fetch_data (fetch_data)
    );

    // Character layer reads halfwords
    rom_client_slot #(.data_t(logic [15:0])) char_slot_i (
        .clk        (clk),
        .reset      (reset),
        .cs         (char_cs),
        .addr       (char_addr),
        .data       (char_data),
        .ok         (char_ok),
        .fetch      (fetch_bus[rom_pkg::CLIENT_CHAR]),
        .fetch_ack  (fetch_ack[rom_pkg::CLIENT_CHAR]),
        .fetch_data (fetch_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
/* Testbench clock and reset */

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/rom_subsys_assertions.sv
/* SDRAM and fetch handshake checks */

`timescale 1ns/10ps
`default_nettype none

module rom_subsys_assertions (
    input wire logic                                clk,
    input wire logic                                reset,
    input wire logic                                downloading,
    input wire logic                                sdram_req,
    input wire rom_pkg::sdram_addr_t                sdram_addr,
    input wire logic                                sdram_ack,
    input wire logic [rom_pkg::NUM_CLIENTS-1:0]     fetch_ack
);

    int fail_count = 0;

    // Address held until the SDRAM takes it
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        sdram_req && !sdram_ack |=> $stable(sdram_addr))
        else begin
            $error("sdram_addr changed while sdram_req waited");
            fail_count++;
        end

    no_read_in_download: assert property (@(posedge clk) disable iff (reset)
        $rose(sdram_req) |-> !$past(downloading))
        else begin
            $error("SDRAM read started during download");
            fail_count++;
        end

    ack_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(fetch_ack))
        else begin
            $error("fetch_ack not one-hot");
            fail_count++;
        end

endmodule

bind sdram_arbiter rom_subsys_assertions asrt_i (.*);

`default_nettype wire

//--- testbench/tb_rom_subsys.sv
/* ROM subsystem testbench */

`timescale 1ns/10ps
`default_nettype none

module tb_rom_subsys;

    localparam int NUM_DL = 200;
    localparam int NUM_ROUNDS = 60;
    localparam int MAX_WAIT = 200;
    // Three serialized reads at worst 4 + 6 + handshake cycles each
    localparam int WORST_ROUND = 3 * 20;
    localparam int TIMEOUT_NS = (NUM_DL * 2 + (NUM_ROUNDS + 20) * WORST_ROUND + 500) * 20;

    logic clk, reset, downloading, ioctl_wr, sdram_ack, data_rdy;
    logic [21:0] ioctl_addr;
    logic [7:0] ioctl_data, main_data, snd_data;
    logic [15:0] char_data;
    rom_pkg::sdram_addr_t prog_addr, sdram_addr;
    logic [7:0] prog_data;
    logic [1:0] prog_mask;
    logic prog_we, cfg_ack, sdram_req, refresh_en, rom_ready, game_rst;
    rom_pkg::prom_we_t prom_we;
    rom_pkg::cfg_write_t cfg;
    logic [2:0] cs;
    logic main_ok, snd_ok, char_ok;
    rom_pkg::rom_addr_t client_addr [3];
    rom_pkg::sdram_word_t data_read;

    logic [31:0] lfsr_state = 32'hf3a7_bc07;
    int value_errors = 0;
    int other_errors = 0;
    logic read_busy = 1'b0;
    rom_pkg::sdram_addr_t model_base [3];
    rom_pkg::sdram_addr_t req_log [$];
    rom_pkg::rom_addr_t last_addr [3];

    tb_clock_gen clock_i (.clk(clk), .reset(reset));

    rom_subsys_top dut_i (
        .clk(clk), .reset(reset), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
        .prog_we(prog_we), .prom_we(prom_we), .cfg(cfg), .cfg_ack(cfg_ack),
        .main_cs(cs[0]), .main_addr(client_addr[0]), .main_data(main_data),
        .main_ok(main_ok), .snd_cs(cs[1]), .snd_addr(client_addr[1]),
        .snd_data(snd_data), .snd_ok(snd_ok), .char_cs(cs[2]),
        .char_addr(client_addr[2]), .char_data(char_data), .char_ok(char_ok),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read), .refresh_en(refresh_en),
        .rom_ready(rom_ready), .game_rst(game_rst)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Every SDRAM image halfword depends on the whole address
    function automatic logic [15:0] image_half(input rom_pkg::sdram_addr_t a);
        return a[15:0] ^ {a[21:16], a[21:12]} ^ 16'h5a3c;
    endfunction

    function automatic rom_pkg::sdram_addr_t half_index(input int c, input rom_pkg::rom_addr_t a);
        return (c == 2) ? rom_pkg::sdram_addr_t'(a) : rom_pkg::sdram_addr_t'(a >> 1);
    endfunction

    task automatic check_prog(input string name, input rom_pkg::sdram_addr_t e_addr,
                              input logic [7:0] e_data, input logic [1:0] e_mask,
                              input logic e_we);
        if ({prog_addr, prog_data, prog_mask, prog_we} !== {e_addr, e_data, e_mask, e_we}) begin
            $display("Error %s: expected addr %h data %h mask %b we %b, actual %h %h %b %b",
                     name, e_addr, e_data, e_mask, e_we,
                     prog_addr, prog_data, prog_mask, prog_we);
            value_errors++;
        end
    endtask

    task automatic check_prom(input string name, input rom_pkg::prom_we_t e,
                              input rom_pkg::prom_we_t a);
        if (a !== e) begin
            $display("Error %s: expected %b, actual %b", name, e, a);
            value_errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] e, input logic [7:0] a);
        if (a !== e) begin
            $display("Error %s: expected %h, actual %h", name, e, a);
            value_errors++;
        end
    endtask

    task automatic check_half(input string name, input logic [15:0] e, input logic [15:0] a);
        if (a !== e) begin
            $display("Error %s: expected %h, actual %h", name, e, a);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic e, input logic a);
        if (a !== e) begin
            $display("Error %s: expected %b, actual %b", name, e, a);
            value_errors++;
        end
    endtask

    task automatic check_level(input string name, input logic e_rst);
        if ({game_rst, rom_ready} !== {e_rst, !e_rst}) begin
            $display("Error %s: expected game_rst %b rom_ready %b, actual %b %b",
                     name, e_rst, !e_rst, game_rst, rom_ready);
            value_errors++;
        end
    endtask

    // Drives one client, waits for ok and returns the cycles waited
    task automatic fetch_check(input int c, input rom_pkg::rom_addr_t a, input string name,
                               output int waited);
        logic [15:0] h;
        logic ok;
        @(negedge clk);
        cs[c] = 1'b1;
        client_addr[c] = a;
        waited = 0;
        #2;
        ok = (c == 0) ? main_ok : (c == 1) ? snd_ok : char_ok;
        while (!ok && waited < MAX_WAIT) begin
            @(negedge clk);
            #2;
            ok = (c == 0) ? main_ok : (c == 1) ? snd_ok : char_ok;
            waited++;
        end
        h = image_half(model_base[c] + half_index(c, a));
        if (!ok) begin
            $display("Client %0d never raised ok for address %h", c, a);
            other_errors++;
        end else if (c == 2) begin
            check_half(name, h, char_data);
        end else begin
            check_byte(name, a[0] ? h[15:8] : h[7:0], (c == 0) ? main_data : snd_data);
        end
        last_addr[c] = a;
        @(negedge clk);
        cs[c] = 1'b0;
    endtask

    task automatic cfg_write(input rom_pkg::client_idx_t sel, input rom_pkg::sdram_addr_t base);
        int n;
        @(negedge clk);
        cfg = '{req: 1'b1, sel: sel, base: base};
        n = 0;
        while (!cfg_ack && n < MAX_WAIT) begin
            @(negedge clk);
            n++;
        end
        cfg.req = 1'b0;
        while (cfg_ack && n < MAX_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= MAX_WAIT) begin
            $display("Configuration handshake to index %0d did not complete", sel);
            other_errors++;
        end
        if (sel < 3) begin
            model_base[sel] = base;
        end
    endtask

    // SDRAM model with random ack and data delays
    initial begin
        rom_pkg::sdram_addr_t a;
        sdram_ack = 1'b0;
        data_rdy = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (sdram_req && !reset) begin
                a = sdram_addr;
                req_log.push_back(a);
                repeat (rand_bits(2)) @(negedge clk);
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                repeat (1 + rand_bits(3) % 5) @(negedge clk);
                data_rdy = 1'b1;
                data_read = {image_half(a + 1), image_half(a)};
                @(negedge clk);
                data_rdy = 1'b0;
            end
        end
    end

    // A read is in flight from its sdram_ack until data_rdy is taken
    always @(posedge clk) begin
        if (reset || data_rdy) begin
            read_busy <= 1'b0;
        end else if (sdram_req && sdram_ack) begin
            read_busy <= 1'b1;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (sdram_req && !rom_ready) begin
                $display("sdram_req seen before rom_ready");
                other_errors++;
            end
            check_flag("refresh_en", !(sdram_req || read_busy), refresh_en);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [21:0] a;
        rom_pkg::prom_we_t e_prom;
        logic [21:0] off;
        logic [2:0] en;
        rom_pkg::rom_addr_t rnd_addr [3];
        rom_pkg::sdram_addr_t w [3];
        int n, waited, log_start;
        downloading = 1'b1;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        cfg = '0;
        cs = '0;
        for (int c = 0; c < 3; c++) begin
            client_addr[c] = '0;
            last_addr[c] = '0;
        end
        model_base[0] = rom_pkg::DEFAULT_BASES.main_base;
        model_base[1] = rom_pkg::DEFAULT_BASES.snd_base;
        model_base[2] = rom_pkg::DEFAULT_BASES.char_base;
        @(negedge clk);
        while (reset) @(negedge clk);

        // A main miss raised during the download has to wait for rom_ready
        cs[0] = 1'b1;
        client_addr[0] = 16'h0246;
        @(negedge clk);
        cs[0] = 1'b0;

        // About half the loader writes land in the PROM area
        for (int i = 0; i < NUM_DL; i++) begin
            a = rand_bits(1) ? rom_pkg::PROM_START + 22'(rand_bits(11)) : 22'(rand_bits(17));
            ioctl_addr = a;
            ioctl_data = 8'(rand_bits(8));
            ioctl_wr = 1'b1;
            @(negedge clk);
            ioctl_wr = 1'b0;
            off = a - rom_pkg::PROM_START;
            e_prom = '0;
            if (a >= rom_pkg::PROM_START && off / 256 < rom_pkg::NUM_PROMS) begin
                e_prom[off / 256] = 1'b1;
            end
            check_prom($sformatf("prom_we %0d", i), e_prom, prom_we);
            check_prog($sformatf("prog %0d", i),
                       (a >= rom_pkg::PROM_START) ? {14'd0, a[7:0]} : a >> 1, ioctl_data,
                       a[0] ? 2'b01 : 2'b10, a < rom_pkg::PROM_START);
            check_level("reset in download", 1'b1);
            // Strobes last one cycle per write
            @(negedge clk);
            check_prom($sformatf("prom_we idle %0d", i), '0, prom_we);
            check_flag($sformatf("prog_we idle %0d", i), 1'b0, prog_we);
        end

        // Reset tail after the download ends
        downloading = 1'b0;
        n = 0;
        while (game_rst && n < 10) begin
            check_level("reset tail", 1'b1);
            @(negedge clk);
            n++;
        end
        if (n != rom_pkg::RESET_TAIL) begin
            $display("Error reset tail: expected %0d, actual %0d", rom_pkg::RESET_TAIL, n);
            value_errors++;
        end
        check_level("after tail", 1'b0);

        // Random fetches on all clients
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            en = 3'(rand_bits(3));
            for (int c = 0; c < 3; c++) begin
                rnd_addr[c] = 16'(rand_bits(16));
            end
            fork
                if (en[0]) fetch_check(0, rnd_addr[0], $sformatf("main %0d", r), waited);
                if (en[1]) fetch_check(1, rnd_addr[1], $sformatf("snd %0d", r), waited);
                if (en[2]) fetch_check(2, rnd_addr[2], $sformatf("char %0d", r), waited);
            join
        end

        // Cache hit in the same word
        fetch_check(0, 16'h1234, "main miss", waited);
        n = req_log.size();
        fetch_check(0, 16'h1237, "main hit", waited);
        repeat (4) @(negedge clk);
        if (waited != 0 || req_log.size() != n) begin
            $display("Cache hit on main took %0d cycles or issued a read", waited);
            other_errors++;
        end

        // Index 3 configuration writes must have no effect
        cfg_write(rom_pkg::CLIENT_SND, 22'h012340);
        cfg_write(2'd3, 22'h3ffff0);
        for (int c = 0; c < 3; c++) begin
            fetch_check(c, last_addr[c] ^ 16'h4000, $sformatf("cfg client %0d", c), waited);
        end

        // All three clients miss together
        repeat (8) @(negedge clk);
        log_start = req_log.size();
        for (int c = 0; c < 3; c++) begin
            w[c] = model_base[c] + (half_index(c, last_addr[c] ^ 16'h4000) & ~22'd1);
        end
        fork
            fetch_check(0, last_addr[0] ^ 16'h4000, "contend main", waited);
            fetch_check(1, last_addr[1] ^ 16'h4000, "contend snd", waited);
            fetch_check(2, last_addr[2] ^ 16'h4000, "contend char", waited);
        join
        if (req_log.size() != log_start + 3) begin
            $display("Contention issued %0d reads instead of 3", req_log.size() - log_start);
            other_errors++;
        end else begin
            for (int c = 0; c < 3; c++) begin
                if (req_log[log_start + c] !== w[c]) begin
                    $display("Error contention order %0d: expected %h, actual %h",
                             c, w[c], req_log[log_start + c]);
                    value_errors++;
                end
            end
        end

        $display("Errors: %0d wrong values, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, dut_i.arbiter_i.asrt_i.fail_count);
        if (value_errors + other_errors + dut_i.arbiter_i.asrt_i.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
common/rom_pkg.sv
rom_fetch/rom_client_slot.sv
rom_fetch/sdram_arbiter.sv
logic/rom_download.sv
logic/region_cfg.sv
logic/rom_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/rom_subsys_assertions.sv
testbench/tb_rom_subsys.sv

//--- Bender.yml
package:
  name: rom_subsys

sources:
  - common/rom_pkg.sv
  - rom_fetch/rom_client_slot.sv
  - rom_fetch/sdram_arbiter.sv
  - logic/rom_download.sv
  - logic/region_cfg.sv
  - logic/rom_subsys_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/rom_subsys_assertions.sv
      - testbench/tb_rom_subsys.sv
